/* all.f */
+incdir+src
src/opreq_cmd_pkg.sv
src/opreq_vrf_pkg.sv
src/opreq_cmd_decode.sv
src/opreq_requester.sv
src/opreq_bank_arbiter.sv
src/opreq_top.sv
verif/opreq_tb.sv

/* src/opreq_bank_arbiter.sv */
/*
 * VRF bank arbiter
 * Write-back requests always win over operand reads; round robin
 * inside each class, one access per cycle
 */

`timescale 1ns/1ps

`include "opreq_defs.svh"

module opreq_bank_arbiter (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [`OPREQ_NR_QUEUES-1:0]                         rd_req_i,
  input  opreq_vrf_pkg::row_t [`OPREQ_NR_QUEUES-1:0]          rd_row_i,
  input  logic [`OPREQ_NR_WRITERS-1:0]                        wb_req_i,
  input  opreq_vrf_pkg::result_req_t [`OPREQ_NR_WRITERS-1:0]  wb_i,
  output logic [`OPREQ_NR_QUEUES-1:0]                         rd_gnt_o,
  output logic [`OPREQ_NR_WRITERS-1:0]                        wb_gnt_o,
  output logic                                                vrf_req_o,
  output opreq_vrf_pkg::vrf_payload_t                         vrf_o
);

  localparam int unsigned NrQueues  = `OPREQ_NR_QUEUES;
  localparam int unsigned NrWriters = `OPREQ_NR_WRITERS;
  localparam int unsigned MaxN      = (NrQueues > NrWriters) ? NrQueues : NrWriters;
  localparam int unsigned PtrW      = (MaxN > 1) ? $clog2(MaxN) : 1;

  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW:0]   rd_pick;
  logic [PtrW:0]   wr_pick;
  logic [PtrW-1:0] rd_idx;
  logic [PtrW-1:0] wr_idx;

  // First requester at or after ptr, MSB flags a hit
  function automatic logic [PtrW:0] rr_pick(input logic [MaxN-1:0] req,
                                            input logic [PtrW-1:0] ptr,
                                            input int unsigned     n);
    logic [PtrW:0] pick;
    int unsigned   idx;
    pick = '0;
    for (int unsigned i = 0; i < MaxN; i++) begin
      idx = (ptr + i) % n;
      if (i < n && !pick[PtrW] && req[idx]) begin
        pick = {1'b1, PtrW'(idx)};
      end
    end
    return pick;
  endfunction

  assign wr_pick = rr_pick(MaxN'(wb_req_i), wr_ptr_q, NrWriters);
  assign rd_pick = rr_pick(MaxN'(rd_req_i), rd_ptr_q, NrQueues);
  assign wr_idx  = wr_pick[PtrW-1:0];
  assign rd_idx  = rd_pick[PtrW-1:0];

  //////////////////////////////
  // Grant and payload mux
  //////////////////////////////

  always_comb begin
    rd_gnt_o  = '0;
    wb_gnt_o  = '0;
    vrf_o     = '0;
    vrf_req_o = wr_pick[PtrW] || rd_pick[PtrW];
    if (wr_pick[PtrW]) begin
      wb_gnt_o[wr_idx] = 1'b1;
      vrf_o.row        = wb_i[wr_idx].addr[`OPREQ_VADDR_W-1:opreq_vrf_pkg::BankW];
      vrf_o.wen        = 1'b1;
      vrf_o.wdata      = wb_i[wr_idx].wdata;
      vrf_o.be         = wb_i[wr_idx].be;
    end else if (rd_pick[PtrW]) begin
      rd_gnt_o[rd_idx] = 1'b1;
      vrf_o.row        = rd_row_i[rd_idx];
      vrf_o.tgt        = opreq_vrf_pkg::queue_idx_t'(rd_idx);
    end
  end

  // The VRF takes every request, so a pick is final
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else if (wr_pick[PtrW]) begin
      wr_ptr_q <= PtrW'((wr_idx + 1) % NrWriters);
    end else if (rd_pick[PtrW]) begin
      rd_ptr_q <= PtrW'((rd_idx + 1) % NrQueues);
    end
  end

  a_single_grant : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0({rd_gnt_o, wb_gnt_o})
  );

endmodule

/* src/opreq_cmd_decode.sv */
/*
 * Command decoder
 * Four-phase slave toward the lane sequencer; turns one command into
 * a start word address and a word count held in a single-entry slot
 */

`timescale 1ns/1ps

`include "opreq_defs.svh"

module opreq_cmd_decode (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cmd_req_i,
  input  opreq_cmd_pkg::operand_cmd_t cmd_i,
  output logic                        cmd_ack_o,
  output logic                        job_valid_o,
  output opreq_cmd_pkg::operand_job_t job_o,
  input  logic                        job_ready_i
);

  logic                        ack_q;
  logic                        slot_q;
  opreq_cmd_pkg::operand_job_t job_q;
  opreq_cmd_pkg::operand_job_t job_d;
  logic                        capture;
  logic [1:0]                  shamt;
  logic [`OPREQ_VL_W:0]        round_up;
  logic [`OPREQ_VL_W:0]        words_full;
  opreq_cmd_pkg::vaddr_t       reg_base;
  opreq_cmd_pkg::vaddr_t       offset;

  // Take a new command only when the last handshake is closed and the slot is free
  assign capture = cmd_req_i && !ack_q && !slot_q;

  // log2 of the elements per 64-bit word
  assign shamt = 2'd3 - cmd_i.eew;

  always_comb begin
    round_up    = ({{`OPREQ_VL_W{1'b0}}, 1'b1} << shamt) - 1'b1;
    words_full  = ({1'b0, cmd_i.vl} + round_up) >> shamt;
    reg_base    = opreq_cmd_pkg::vaddr_t'(cmd_i.vs * `OPREQ_REG_WORDS);
    offset      = opreq_cmd_pkg::vaddr_t'(cmd_i.vstart >> shamt);
    job_d.addr  = reg_base + offset;
    job_d.words = words_full[`OPREQ_VL_W-1:0];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      slot_q <= 1'b0;
    end else begin
      if (capture) begin
        ack_q <= 1'b1;
      end else if (!cmd_req_i) begin
        ack_q <= 1'b0;
      end
      // vl zero is acknowledged but never reaches the requester
      if (capture && cmd_i.vl != '0) begin
        slot_q <= 1'b1;
      end else if (job_ready_i) begin
        slot_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      job_q <= job_d;
    end
  end

  assign cmd_ack_o   = ack_q;
  assign job_valid_o = slot_q;
  assign job_o       = job_q;

  // Ack only rises while the request is still held
  a_ack_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(cmd_ack_o) |-> cmd_req_i
  );

endmodule

/* src/opreq_cmd_pkg.sv */
/*
 * Command-side types
 * Sequencer commands and the decoded read jobs derived from them
 */

`include "opreq_defs.svh"

package opreq_cmd_pkg;

  // Element width, code is log2 of the width in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef logic [`OPREQ_VADDR_W-1:0] vaddr_t;
  typedef logic [`OPREQ_VL_W-1:0]    vlen_t;
  typedef logic [`OPREQ_VREG_W-1:0]  vreg_t;

  typedef struct packed {
    vreg_t vs;
    vew_e  eew;
    vlen_t vl;
    vlen_t vstart;
  } operand_cmd_t;

  // Word-granular view of one operand read
  typedef struct packed {
    vaddr_t addr;
    vlen_t  words;
  } operand_job_t;

endpackage

/* src/opreq_defs.svh */
/*
 * Operand requester constants
 * Sizes of the lane's register file, operand queues and write ports
 */

`ifndef OPREQ_DEFS_SVH
`define OPREQ_DEFS_SVH

// Register file organization
`define OPREQ_NR_BANKS 4
`define OPREQ_REG_WORDS 16

// Requesters and write-back ports (ALU, load)
`define OPREQ_NR_QUEUES 2
`define OPREQ_NR_WRITERS 2

// Field widths
`define OPREQ_ELEN 64
`define OPREQ_VADDR_W 8
`define OPREQ_VL_W 9
`define OPREQ_VREG_W 5

`endif

/* src/opreq_requester.sv */
/*
 * Operand requester
 * Walks the words of one operand and requests the bank of each word
 * while its operand queue has room
 */

`timescale 1ns/1ps

`include "opreq_defs.svh"

module opreq_requester (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        job_valid_i,
  input  opreq_cmd_pkg::operand_job_t job_i,
  output logic                        job_ready_o,
  input  logic                        queue_ready_i,
  output logic                        rd_req_o,
  output opreq_vrf_pkg::bank_idx_t    rd_bank_o,
  output opreq_vrf_pkg::row_t         rd_row_o,
  input  logic                        gnt_i,
  output logic                        issued_o
);

  opreq_vrf_pkg::req_state_e   state_q;
  opreq_vrf_pkg::req_state_e   state_d;
  opreq_cmd_pkg::operand_job_t cur_q;
  opreq_cmd_pkg::operand_job_t cur_d;
  logic                        fire;
  logic                        last;

  //////////////////////////////
  // Bank request
  //////////////////////////////

  // Address is held while the queue is full or the bank is busy
  assign rd_req_o  = (state_q == opreq_vrf_pkg::REQUESTING) && queue_ready_i;
  assign rd_bank_o = cur_q.addr[opreq_vrf_pkg::BankW-1:0];
  assign rd_row_o  = cur_q.addr[`OPREQ_VADDR_W-1:opreq_vrf_pkg::BankW];

  assign fire     = rd_req_o && gnt_i;
  assign last     = fire && (cur_q.words == opreq_cmd_pkg::vlen_t'(1));
  assign issued_o = fire;

  // Next job can be taken in the cycle the final word is granted
  assign job_ready_o = (state_q == opreq_vrf_pkg::IDLE) || last;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    cur_d   = cur_q;
    if (fire) begin
      cur_d.addr  = cur_q.addr + 1'b1;
      cur_d.words = cur_q.words - 1'b1;
    end
    if (job_valid_i && job_ready_o) begin
      state_d = opreq_vrf_pkg::REQUESTING;
      cur_d   = job_i;
    end else if (last) begin
      state_d = opreq_vrf_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= opreq_vrf_pkg::IDLE;
      cur_q   <= '0;
    end else begin
      state_q <= state_d;
      cur_q   <= cur_d;
    end
  end

  // Every read belongs to an active job with words left
  a_no_read_when_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_req_o |-> (state_q == opreq_vrf_pkg::REQUESTING && cur_q.words != '0)
  );

endmodule

/* src/opreq_top.sv */
/*
 * Operand requester lane top
 * One decoder and requester per operand queue, one arbiter per VRF bank,
 * with bank steering of requests and gathering of grants
 */

`timescale 1ns/1ps

`include "opreq_defs.svh"

module opreq_top (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [`OPREQ_NR_QUEUES-1:0]                         cmd_req_i,
  input  opreq_cmd_pkg::operand_cmd_t [`OPREQ_NR_QUEUES-1:0]  cmd_i,
  output logic [`OPREQ_NR_QUEUES-1:0]                         cmd_ack_o,
  input  logic [`OPREQ_NR_QUEUES-1:0]                         operand_queue_ready_i,
  output logic [`OPREQ_NR_QUEUES-1:0]                         operand_issued_o,
  input  logic [`OPREQ_NR_WRITERS-1:0]                        wb_req_i,
  input  opreq_vrf_pkg::result_req_t [`OPREQ_NR_WRITERS-1:0]  wb_i,
  output logic [`OPREQ_NR_WRITERS-1:0]                        wb_gnt_o,
  output logic [`OPREQ_NR_BANKS-1:0]                          vrf_req_o,
  output opreq_vrf_pkg::vrf_payload_t [`OPREQ_NR_BANKS-1:0]   vrf_o
);

  localparam int unsigned NrBanks   = `OPREQ_NR_BANKS;
  localparam int unsigned NrQueues  = `OPREQ_NR_QUEUES;
  localparam int unsigned NrWriters = `OPREQ_NR_WRITERS;

  logic [NrQueues-1:0]                        job_valid;
  logic [NrQueues-1:0]                        job_ready;
  opreq_cmd_pkg::operand_job_t [NrQueues-1:0] job;
  logic [NrQueues-1:0]                        rd_req;
  logic [NrQueues-1:0]                        rd_gnt;
  opreq_vrf_pkg::bank_idx_t [NrQueues-1:0]    rd_bank;
  opreq_vrf_pkg::row_t [NrQueues-1:0]         rd_row;
  logic [NrBanks-1:0][NrQueues-1:0]           bank_rd_req;
  logic [NrBanks-1:0][NrQueues-1:0]           bank_rd_gnt;
  logic [NrBanks-1:0][NrWriters-1:0]          bank_wb_req;
  logic [NrBanks-1:0][NrWriters-1:0]          bank_wb_gnt;

  //////////////////////////////
  // Per operand queue
  //////////////////////////////

  for (genvar q = 0; q < NrQueues; q++) begin : gen_queue
    opreq_cmd_decode u_decode (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cmd_req_i   (cmd_req_i[q]),
      .cmd_i       (cmd_i[q]),
      .cmd_ack_o   (cmd_ack_o[q]),
      .job_valid_o (job_valid[q]),
      .job_o       (job[q]),
      .job_ready_i (job_ready[q])
    );

    opreq_requester u_requester (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .job_valid_i   (job_valid[q]),
      .job_i         (job[q]),
      .job_ready_o   (job_ready[q]),
      .queue_ready_i (operand_queue_ready_i[q]),
      .rd_req_o      (rd_req[q]),
      .rd_bank_o     (rd_bank[q]),
      .rd_row_o      (rd_row[q]),
      .gnt_i         (rd_gnt[q]),
      .issued_o      (operand_issued_o[q])
    );
  end

  // Steer each request to the bank of its word address
  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      for (int q = 0; q < NrQueues; q++) begin
        bank_rd_req[b][q] = rd_req[q] && (rd_bank[q] == opreq_vrf_pkg::bank_idx_t'(b));
      end
      for (int w = 0; w < NrWriters; w++) begin
        bank_wb_req[b][w] = wb_req_i[w] &&
                            (wb_i[w].addr[opreq_vrf_pkg::BankW-1:0] ==
                             opreq_vrf_pkg::bank_idx_t'(b));
      end
    end
  end

  // At most one bank grants a given requester
  always_comb begin
    rd_gnt   = '0;
    wb_gnt_o = '0;
    for (int b = 0; b < NrBanks; b++) begin
      rd_gnt   = rd_gnt | bank_rd_gnt[b];
      wb_gnt_o = wb_gnt_o | bank_wb_gnt[b];
    end
  end

  //////////////////////////////
  // Per VRF bank
  //////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    opreq_bank_arbiter u_arbiter (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .rd_req_i  (bank_rd_req[b]),
      .rd_row_i  (rd_row),
      .wb_req_i  (bank_wb_req[b]),
      .wb_i      (wb_i),
      .rd_gnt_o  (bank_rd_gnt[b]),
      .wb_gnt_o  (bank_wb_gnt[b]),
      .vrf_req_o (vrf_req_o[b]),
      .vrf_o     (vrf_o[b])
    );
  end

endmodule

/* src/opreq_vrf_pkg.sv */
/*
 * Bank-side types
 * Requester states, per-bank VRF payload and write-back requests
 */

`include "opreq_defs.svh"

package opreq_vrf_pkg;

  localparam int unsigned BankW  = $clog2(`OPREQ_NR_BANKS);
  localparam int unsigned RowW   = `OPREQ_VADDR_W - BankW;
  localparam int unsigned QueueW = (`OPREQ_NR_QUEUES > 1) ? $clog2(`OPREQ_NR_QUEUES) : 1;

  typedef enum logic {
    IDLE,
    REQUESTING
  } req_state_e;

  typedef logic [BankW-1:0]           bank_idx_t;
  typedef logic [RowW-1:0]            row_t;
  typedef logic [QueueW-1:0]          queue_idx_t;
  typedef logic [`OPREQ_ELEN-1:0]     elen_t;
  typedef logic [`OPREQ_ELEN/8-1:0]   strb_t;

  // What one bank sees in a cycle
  typedef struct packed {
    row_t       row;
    logic       wen;
    elen_t      wdata;
    strb_t      be;
    queue_idx_t tgt;
  } vrf_payload_t;

  // Result from a write-back unit, addr is a full word address
  typedef struct packed {
    logic [`OPREQ_VADDR_W-1:0] addr;
    elen_t                     wdata;
    strb_t                     be;
  } result_req_t;

endpackage

/* verif/opreq_cases.txt */
# C queue vs eew vl vstart exp_addr exp_words   (hex, eew 0..3 = 8..64 bit)
# W port addr wdata be                          (hex)
C 0 01 3 005 000 10 005
C 1 02 0 011 000 20 003
C 0 03 1 00a 008 32 003
W 0 12 0123456789abcdef ff
C 1 04 2 007 003 41 004
W 1 41 fedcba9876543210 0f
C 0 05 3 000 000 50 000
C 1 06 0 000 010 62 000
C 0 07 3 00c 004 74 00c
W 0 75 00000000cafef00d 33
W 1 76 a5a5a5a55a5a5a5a c3
C 1 0e 1 021 000 e0 009
C 0 0d 2 01f 00a d5 010
W 0 e1 1122334455667788 ff
C 0 00 0 008 007 00 001
C 1 01 3 003 002 12 003
W 1 dc 0f0f0f0f0f0f0f0f 81

/* verif/opreq_tb.sv */
/*
 * Operand requester testbench
 * Replays commands and writes from the cases file, checks the four-phase
 * handshake, read address sequences, write priority and issued pulses
 */

`timescale 1ns/1ps

`include "opreq_defs.svh"

module opreq_tb;

  localparam int unsigned nr_queues       = `OPREQ_NR_QUEUES;
  localparam int unsigned nr_banks        = `OPREQ_NR_BANKS;
  localparam int unsigned cycles_per_case = 200;

  typedef struct packed {
    logic                        is_write;
    logic [7:0]                  port;
    opreq_cmd_pkg::operand_cmd_t cmd;
    opreq_cmd_pkg::operand_job_t exp;
    opreq_vrf_pkg::result_req_t  wb;
  } case_t;

  logic                                                clk_i;
  logic                                                rst_ni;
  logic [`OPREQ_NR_QUEUES-1:0]                         cmd_req_i;
  opreq_cmd_pkg::operand_cmd_t [`OPREQ_NR_QUEUES-1:0]  cmd_i;
  logic [`OPREQ_NR_QUEUES-1:0]                         cmd_ack_o;
  logic [`OPREQ_NR_QUEUES-1:0]                         operand_queue_ready_i;
  logic [`OPREQ_NR_QUEUES-1:0]                         operand_issued_o;
  logic [`OPREQ_NR_WRITERS-1:0]                        wb_req_i;
  opreq_vrf_pkg::result_req_t [`OPREQ_NR_WRITERS-1:0]  wb_i;
  logic [`OPREQ_NR_WRITERS-1:0]                        wb_gnt_o;
  logic [`OPREQ_NR_BANKS-1:0]                          vrf_req_o;
  opreq_vrf_pkg::vrf_payload_t [`OPREQ_NR_BANKS-1:0]   vrf_o;

  case_t                 cases[$];
  int unsigned           n_cases;
  int unsigned           n_writes;
  int unsigned           n_mismatch;
  int unsigned           n_other;
  opreq_cmd_pkg::vaddr_t exp_addr[nr_queues][$];
  int unsigned           expected_reads[nr_queues];
  int unsigned           reads_seen[nr_queues];
  int unsigned           issued_seen[nr_queues];
  int unsigned           writes_seen;
  logic [`OPREQ_NR_QUEUES-1:0] req_prev;
  logic [`OPREQ_NR_QUEUES-1:0] ack_prev;

  opreq_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic compare_hex(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      n_mismatch++;
      $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatch, %0d other", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  //////////////////////////////
  // Cases file
  //////////////////////////////

  // Lines are C queue vs eew vl vstart addr words, or W port addr data be
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [63:0] f[7];
    case_t       c;
    fd = $fopen("verif/opreq_cases.txt", "r");
    assert (fd != 0) else begin
      n_other++;
      $display("Cannot open the cases file");
    end
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          c = '0;
          n = $sscanf(line, "C %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
          if (n == 7) begin
            c.port       = 8'(f[0]);
            c.cmd.vs     = opreq_cmd_pkg::vreg_t'(f[1]);
            c.cmd.eew    = opreq_cmd_pkg::vew_e'(f[2][1:0]);
            c.cmd.vl     = opreq_cmd_pkg::vlen_t'(f[3]);
            c.cmd.vstart = opreq_cmd_pkg::vlen_t'(f[4]);
            c.exp.addr   = opreq_cmd_pkg::vaddr_t'(f[5]);
            c.exp.words  = opreq_cmd_pkg::vlen_t'(f[6]);
            cases.push_back(c);
          end else begin
            n = $sscanf(line, "W %h %h %h %h", f[0], f[1], f[2], f[3]);
            assert (n == 4) else begin
              n_other++;
              $display("Unreadable line in the cases file: %s", line);
            end
            c.is_write = 1'b1;
            c.port     = 8'(f[0]);
            c.wb.addr  = opreq_cmd_pkg::vaddr_t'(f[1]);
            c.wb.wdata = opreq_vrf_pkg::elen_t'(f[2]);
            c.wb.be    = opreq_vrf_pkg::strb_t'(f[3]);
            if (n == 4) begin
              cases.push_back(c);
              n_writes++;
            end
          end
        end
      end
      $fclose(fd);
    end
    n_cases = cases.size();
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic send_cmd(input case_t c);
    int q;
    q = int'(c.port);
    for (int i = 0; i < int'(c.exp.words); i++) begin
      exp_addr[q].push_back(opreq_cmd_pkg::vaddr_t'(c.exp.addr + i));
    end
    expected_reads[q] += c.exp.words;
    @(posedge clk_i);
    cmd_i[q]     <= c.cmd;
    cmd_req_i[q] <= 1'b1;
    @(posedge clk_i);
    while (!cmd_ack_o[q]) @(posedge clk_i);
    cmd_req_i[q] <= 1'b0;
    @(posedge clk_i);
    while (cmd_ack_o[q]) @(posedge clk_i);
  endtask

  // A lone writer beats any read, so the grant comes in the first cycle
  task automatic send_write(input case_t c);
    int                          p;
    int                          b;
    opreq_vrf_pkg::vrf_payload_t got;
    p = int'(c.port);
    b = int'(c.wb.addr[opreq_vrf_pkg::BankW-1:0]);
    @(posedge clk_i);
    wb_i[p]     <= c.wb;
    wb_req_i[p] <= 1'b1;
    @(posedge clk_i);
    got = vrf_o[b];
    compare_hex($sformatf("wb_gnt_o[%0d]", p), 64'(wb_gnt_o[p]), 64'h1);
    compare_hex($sformatf("vrf_req_o[%0d]", b), 64'(vrf_req_o[b]), 64'h1);
    compare_hex($sformatf("vrf_o[%0d].wen", b), 64'(got.wen), 64'h1);
    compare_hex($sformatf("vrf_o[%0d].row", b), 64'(got.row),
                64'(c.wb.addr[`OPREQ_VADDR_W-1:opreq_vrf_pkg::BankW]));
    compare_hex($sformatf("vrf_o[%0d].wdata", b), got.wdata, c.wb.wdata);
    compare_hex($sformatf("vrf_o[%0d].be", b), 64'(got.be), 64'(c.wb.be));
    wb_req_i[p] <= 1'b0;
  endtask

  task automatic check_idle();
    compare_hex("cmd_ack_o", 64'(cmd_ack_o), 64'h0);
    compare_hex("vrf_req_o", 64'(vrf_req_o), 64'h0);
    compare_hex("wb_gnt_o", 64'(wb_gnt_o), 64'h0);
    compare_hex("operand_issued_o", 64'(operand_issued_o), 64'h0);
  endtask

  function automatic bit reads_done();
    bit done;
    done = 1'b1;
    for (int q = 0; q < nr_queues; q++) begin
      if (reads_seen[q] < expected_reads[q]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // Random gaps, about one cycle in four
  always @(posedge clk_i) begin
    for (int q = 0; q < nr_queues; q++) begin
      operand_queue_ready_i[q] <= ($urandom % 4) != 0;
    end
  end

  //////////////////////////////
  // Bank and handshake monitor
  //////////////////////////////

  always @(posedge clk_i) begin : monitor
    opreq_vrf_pkg::vrf_payload_t p;
    opreq_cmd_pkg::vaddr_t       a;
    int                          q;
    for (int b = 0; b < nr_banks; b++) begin
      p = vrf_o[b];
      if (vrf_req_o[b] && p.wen) begin
        writes_seen++;
      end else if (vrf_req_o[b]) begin
        q = int'(p.tgt);
        assert (operand_queue_ready_i[q]) else begin
          n_other++;
          $display("Read for queue %0d while its operand queue was not ready", q);
        end
        assert (exp_addr[q].size() != 0) else begin
          n_other++;
          $display("Unexpected read for queue %0d on bank %0d", q, b);
        end
        if (exp_addr[q].size() != 0) begin
          a = exp_addr[q].pop_front();
          compare_hex($sformatf("vrf_o bank (queue %0d)", q), 64'(b),
                      64'(a[opreq_vrf_pkg::BankW-1:0]));
          compare_hex($sformatf("vrf_o[%0d].row", b), 64'(p.row),
                      64'(a[`OPREQ_VADDR_W-1:opreq_vrf_pkg::BankW]));
        end
        reads_seen[q]++;
      end
    end
    for (int i = 0; i < nr_queues; i++) begin
      if (operand_issued_o[i]) begin
        issued_seen[i]++;
      end
      if (cmd_ack_o[i] && !ack_prev[i]) begin
        assert (req_prev[i]) else begin
          n_other++;
          $display("cmd_ack_o[%0d] rose without a pending request", i);
        end
      end
      if (!cmd_ack_o[i] && ack_prev[i]) begin
        assert (!req_prev[i]) else begin
          n_other++;
          $display("cmd_ack_o[%0d] fell while the request was still high", i);
        end
      end
    end
    ack_prev = cmd_ack_o;
    req_prev = cmd_req_i;
  end

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin : main
    rst_ni                = 1'b0;
    cmd_req_i             = '0;
    cmd_i                 = '0;
    operand_queue_ready_i = '1;
    wb_req_i              = '0;
    wb_i                  = '0;
    req_prev              = '0;
    ack_prev              = '0;
    void'($urandom(32'h23bd_59f6));
    load_cases();
    // First edge in reset clears the flops
    @(posedge clk_i);
    repeat (3) begin
      @(posedge clk_i);
      check_idle();
    end
    rst_ni <= 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      check_idle();
    end
    foreach (cases[i]) begin
      if (cases[i].is_write) begin
        send_write(cases[i]);
      end else begin
        send_cmd(cases[i]);
      end
    end
    while (!reads_done()) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    for (int q = 0; q < nr_queues; q++) begin
      compare_hex($sformatf("reads for queue %0d", q), 64'(reads_seen[q]),
                  64'(expected_reads[q]));
      compare_hex($sformatf("operand_issued_o[%0d] pulses", q), 64'(issued_seen[q]),
                  64'(expected_reads[q]));
    end
    compare_hex("write accesses", 64'(writes_seen), 64'(n_writes));
    finish_run();
  end

  initial begin : watchdog
    wait (n_cases != 0);
    repeat (n_cases * cycles_per_case + 50) @(posedge clk_i);
    n_other++;
    $display("Timeout after %0d cycles without finishing", n_cases * cycles_per_case + 50);
    finish_run();
  end

endmodule
